/* rtl/mem_region_consts.svh */
// sizes and address map of the local data memory region
// bank count and bank depth must stay powers of two
// the local space is MR_NUM_BANKS * MR_BANK_WORDS words and aliases above that
`ifndef MEM_REGION_CONSTS_SVH
`define MEM_REGION_CONSTS_SVH

// bus widths, all ports use the same ones
`define MR_ADDR_W 32
`define MR_DATA_W 32

// word interleaved banks, bank index in the low word address bits
`define MR_NUM_BANKS 4
`define MR_BANK_WORDS 256

// upper address bits that select local memory
`define MR_PREFIX_W 12
`define MR_LOCAL_PREFIX 12'h001

`endif

/* rtl/mem_region_pkg.sv */
// common types of the memory region
// widths come from the constants header
`include "mem_region_consts.svh"

package mem_region_pkg;

  // byte address and data word
  typedef logic [`MR_ADDR_W-1:0] addr_t;
  typedef logic [`MR_DATA_W-1:0] data_t;

  // one enable per byte lane
  typedef logic [`MR_DATA_W/8-1:0] be_t;

  // bank index, taken right above the byte offset
  typedef logic [$clog2(`MR_NUM_BANKS)-1:0] bank_sel_t;

  // word inside one bank, above the bank index
  typedef logic [$clog2(`MR_BANK_WORDS)-1:0] word_idx_t;

  // where the outstanding load/store response comes from
  typedef enum logic {
    NONE,
    EXT
  } resp_src_e;

endpackage

/* rtl/mem_port_if.sv */
// one request/grant/response channel into a single bank
// gnt is combinational, rvalid follows a grant by one cycle
`timescale 1ns/1ps
`include "mem_region_consts.svh"

interface mem_port_if;

  logic                      req;
  logic                      gnt;
  mem_region_pkg::word_idx_t word_idx;
  logic                      we;
  mem_region_pkg::be_t       be;
  mem_region_pkg::data_t     wdata;
  logic                      rvalid;
  // only meaningful while rvalid is high on a read
  mem_region_pkg::data_t     rdata;

  // address router side
  modport initiator (output req, word_idx, we, be, wdata, input gnt);

  // bank side
  modport target (input req, word_idx, we, be, wdata, output gnt, rvalid, rdata);

  // response merger side
  modport monitor (input rvalid, rdata);

endinterface

/* rtl/lsu_addr_router.sv */
// routes load/store accesses to a local bank or the external bus
// slave port addresses are always taken as local, upper bits are ignored
// only one external access may be outstanding, the lsu port stalls meanwhile
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module lsu_addr_router (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lsu_req_i,
  input  mem_region_pkg::addr_t lsu_addr_i,
  input  logic                  lsu_we_i,
  input  mem_region_pkg::be_t   lsu_be_i,
  input  mem_region_pkg::data_t lsu_wdata_i,
  output logic                  lsu_gnt_o,
  input  logic                  slv_req_i,
  input  mem_region_pkg::addr_t slv_addr_i,
  input  logic                  slv_we_i,
  input  mem_region_pkg::be_t   slv_be_i,
  input  mem_region_pkg::data_t slv_wdata_i,
  output logic                  slv_gnt_o,
  output logic                  ext_req_o,
  output mem_region_pkg::addr_t ext_addr_o,
  output logic                  ext_we_o,
  output mem_region_pkg::be_t   ext_be_o,
  output mem_region_pkg::data_t ext_wdata_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  mem_port_if.initiator         lsu_bank [`MR_NUM_BANKS],
  mem_port_if.initiator         slv_bank [`MR_NUM_BANKS]
);

  localparam int BANK_LSB = $clog2(`MR_DATA_W/8);
  localparam int WORD_LSB = BANK_LSB + $bits(mem_region_pkg::bank_sel_t);

  mem_region_pkg::resp_src_e pend_q, pend_d;
  mem_region_pkg::bank_sel_t lsu_sel, slv_sel;
  mem_region_pkg::word_idx_t lsu_widx, slv_widx;
  logic                      lsu_local, lsu_block, lsu_local_req;
  logic [`MR_NUM_BANKS-1:0]  lsu_bank_gnt, slv_bank_gnt;

  assign lsu_local     = lsu_addr_i[`MR_ADDR_W-1 -: `MR_PREFIX_W] == `MR_LOCAL_PREFIX;
  assign lsu_block     = (pend_q == mem_region_pkg::EXT);
  assign lsu_local_req = lsu_req_i & lsu_local & ~lsu_block;
  assign ext_req_o     = lsu_req_i & ~lsu_local & ~lsu_block;

  assign lsu_sel  = lsu_addr_i[BANK_LSB +: $bits(mem_region_pkg::bank_sel_t)];
  assign lsu_widx = lsu_addr_i[WORD_LSB +: $bits(mem_region_pkg::word_idx_t)];
  assign slv_sel  = slv_addr_i[BANK_LSB +: $bits(mem_region_pkg::bank_sel_t)];
  assign slv_widx = slv_addr_i[WORD_LSB +: $bits(mem_region_pkg::word_idx_t)];

  // request only on the addressed bank, payload fans out to all
  for (genvar b = 0; b < `MR_NUM_BANKS; b++) begin : g_ch
    assign lsu_bank[b].req      = lsu_local_req & (lsu_sel == mem_region_pkg::bank_sel_t'(b));
    assign lsu_bank[b].word_idx = lsu_widx;
    assign lsu_bank[b].we       = lsu_we_i;
    assign lsu_bank[b].be       = lsu_be_i;
    assign lsu_bank[b].wdata    = lsu_wdata_i;
    assign lsu_bank_gnt[b]      = lsu_bank[b].gnt;

    assign slv_bank[b].req      = slv_req_i & (slv_sel == mem_region_pkg::bank_sel_t'(b));
    assign slv_bank[b].word_idx = slv_widx;
    assign slv_bank[b].we       = slv_we_i;
    assign slv_bank[b].be       = slv_be_i;
    assign slv_bank[b].wdata    = slv_wdata_i;
    assign slv_bank_gnt[b]      = slv_bank[b].gnt;
  end

  // external channel is a pass-through of the lsu fields
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = (lsu_local_req & lsu_bank_gnt[lsu_sel]) | (ext_req_o & ext_gnt_i);
  assign slv_gnt_o = slv_req_i & slv_bank_gnt[slv_sel];

  // stays EXT through the ext_rvalid cycle
  always_comb begin
    pend_d = pend_q;
    if (ext_req_o && ext_gnt_i) begin
      pend_d = mem_region_pkg::EXT;
    end else if (ext_rvalid_i) begin
      pend_d = mem_region_pkg::NONE;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q <= mem_region_pkg::NONE;
    end else begin
      pend_q <= pend_d;
    end
  end

endmodule

/* rtl/mem_bank.sv */
// one word-interleaved bank of the local data memory
// slave port has fixed priority, lsu is granted only when slave is idle
// rdata holds the old word on writes and is not meant to be used there
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module mem_bank (
  input  logic       clk,
  input  logic       rst_n,
  mem_port_if.target lsu_port,
  mem_port_if.target slv_port
);

  localparam int BYTES = `MR_DATA_W / 8;

  mem_region_pkg::data_t     mem_q [`MR_BANK_WORDS];
  mem_region_pkg::data_t     rdata_q;
  mem_region_pkg::word_idx_t widx;
  mem_region_pkg::be_t       be;
  mem_region_pkg::data_t     wdata;
  logic                      acc_en;
  logic                      we;
  logic                      lsu_rvalid_q;
  logic                      slv_rvalid_q;

  // fixed priority arbitration
  assign slv_port.gnt = slv_port.req;
  assign lsu_port.gnt = lsu_port.req & ~slv_port.req;

  assign acc_en = slv_port.req | lsu_port.req;

  // select the winning port's access
  always_comb begin
    if (slv_port.req) begin
      widx  = slv_port.word_idx;
      we    = slv_port.we;
      be    = slv_port.be;
      wdata = slv_port.wdata;
    end else begin
      widx  = lsu_port.word_idx;
      we    = lsu_port.we;
      be    = lsu_port.be;
      wdata = lsu_port.wdata;
    end
  end

  // sram array with byte lanes
  always_ff @(posedge clk) begin
    if (acc_en) begin
      if (we) begin
        for (int i = 0; i < BYTES; i++) begin
          if (be[i]) begin
            mem_q[widx][8*i +: 8] <= wdata[8*i +: 8];
          end
        end
      end
      rdata_q <= mem_q[widx];
    end
  end

  // response one cycle after the grant, on the granted port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_rvalid_q <= 1'b0;
      slv_rvalid_q <= 1'b0;
    end else begin
      lsu_rvalid_q <= lsu_port.gnt;
      slv_rvalid_q <= slv_port.gnt;
    end
  end

  assign lsu_port.rvalid = lsu_rvalid_q;
  assign slv_port.rvalid = slv_rvalid_q;
  assign lsu_port.rdata  = rdata_q;
  assign slv_port.rdata  = rdata_q;

endmodule

/* rtl/resp_merge.sv */
// collects bank and external responses back to their requesters
// at most one source per requester is valid in a cycle, the router
// and the banks guarantee that, so data is a plain and-or select
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module resp_merge (
  mem_port_if.monitor           lsu_bank [`MR_NUM_BANKS],
  mem_port_if.monitor           slv_bank [`MR_NUM_BANKS],
  input  logic                  ext_rvalid_i,
  input  mem_region_pkg::data_t ext_rdata_i,
  output logic                  lsu_rvalid_o,
  output mem_region_pkg::data_t lsu_rdata_o,
  output logic                  slv_rvalid_o,
  output mem_region_pkg::data_t slv_rdata_o
);

  logic [`MR_NUM_BANKS-1:0] lsu_valid;
  logic [`MR_NUM_BANKS-1:0] slv_valid;
  mem_region_pkg::data_t    lsu_data [`MR_NUM_BANKS];
  mem_region_pkg::data_t    slv_data [`MR_NUM_BANKS];

  // flatten the interface arrays
  for (genvar b = 0; b < `MR_NUM_BANKS; b++) begin : g_src
    assign lsu_valid[b] = lsu_bank[b].rvalid;
    assign lsu_data[b]  = lsu_bank[b].rdata;
    assign slv_valid[b] = slv_bank[b].rvalid;
    assign slv_data[b]  = slv_bank[b].rdata;
  end

  assign lsu_rvalid_o = (|lsu_valid) | ext_rvalid_i;
  assign slv_rvalid_o = |slv_valid;

  // external bus is one extra source on the lsu side
  always_comb begin
    lsu_rdata_o = ext_rdata_i & {`MR_DATA_W{ext_rvalid_i}};
    slv_rdata_o = '0;
    for (int b = 0; b < `MR_NUM_BANKS; b++) begin
      lsu_rdata_o = lsu_rdata_o | (lsu_data[b] & {`MR_DATA_W{lsu_valid[b]}});
      slv_rdata_o = slv_rdata_o | (slv_data[b] & {`MR_DATA_W{slv_valid[b]}});
    end
  end

endmodule

/* rtl/mem_region_top.sv */
// local data memory region with a load/store port, an external
// master port into local memory and an outgoing external bus port
// local space is bank count times bank depth words, higher addresses alias
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module mem_region_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  lsu_req_i,
  input  mem_region_pkg::addr_t lsu_addr_i,
  input  logic                  lsu_we_i,
  input  mem_region_pkg::be_t   lsu_be_i,
  input  mem_region_pkg::data_t lsu_wdata_i,
  output logic                  lsu_gnt_o,
  output logic                  lsu_rvalid_o,
  output mem_region_pkg::data_t lsu_rdata_o,
  input  logic                  slv_req_i,
  input  mem_region_pkg::addr_t slv_addr_i,
  input  logic                  slv_we_i,
  input  mem_region_pkg::be_t   slv_be_i,
  input  mem_region_pkg::data_t slv_wdata_i,
  output logic                  slv_gnt_o,
  output logic                  slv_rvalid_o,
  output mem_region_pkg::data_t slv_rdata_o,
  output logic                  ext_req_o,
  output mem_region_pkg::addr_t ext_addr_o,
  output logic                  ext_we_o,
  output mem_region_pkg::be_t   ext_be_o,
  output mem_region_pkg::data_t ext_wdata_o,
  input  logic                  ext_gnt_i,
  input  logic                  ext_rvalid_i,
  input  mem_region_pkg::data_t ext_rdata_i
);

  // one channel per bank and requester
  mem_port_if lsu_ch [`MR_NUM_BANKS] ();
  mem_port_if slv_ch [`MR_NUM_BANKS] ();

  lsu_addr_router i_router (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .slv_req_i    (slv_req_i),
    .slv_addr_i   (slv_addr_i),
    .slv_we_i     (slv_we_i),
    .slv_be_i     (slv_be_i),
    .slv_wdata_i  (slv_wdata_i),
    .slv_gnt_o    (slv_gnt_o),
    .ext_req_o    (ext_req_o),
    .ext_addr_o   (ext_addr_o),
    .ext_we_o     (ext_we_o),
    .ext_be_o     (ext_be_o),
    .ext_wdata_o  (ext_wdata_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .lsu_bank     (lsu_ch),
    .slv_bank     (slv_ch)
  );

  for (genvar b = 0; b < `MR_NUM_BANKS; b++) begin : g_bank
    mem_bank i_bank (
      .clk      (clk),
      .rst_n    (rst_n),
      .lsu_port (lsu_ch[b]),
      .slv_port (slv_ch[b])
    );
  end

  resp_merge i_merge (
    .lsu_bank     (lsu_ch),
    .slv_bank     (slv_ch),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .slv_rvalid_o (slv_rvalid_o),
    .slv_rdata_o  (slv_rdata_o)
  );

endmodule

/* dv/mem_region_sva.sv */
// handshake assertions for mem_region_top, attached with bind
// local lsu grants are told apart from external ones by the address prefix
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module mem_region_sva (
  input logic        clk,
  input logic        rst_n,
  input logic        lsu_req_i,
  input logic [31:0] lsu_addr_i,
  input logic        lsu_gnt_o,
  input logic        lsu_rvalid_o,
  input logic        slv_req_i,
  input logic        slv_gnt_o,
  input logic        slv_rvalid_o,
  input logic        ext_req_o,
  input logic        ext_gnt_i,
  input logic        ext_rvalid_i
);

  logic lsu_local;
  logic ext_pend_q;

  assign lsu_local = lsu_addr_i[31:20] == `MR_LOCAL_PREFIX;

  // outstanding external access, through its response cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_pend_q <= 1'b0;
    end else if (ext_req_o && ext_gnt_i) begin
      ext_pend_q <= 1'b1;
    end else if (ext_rvalid_i) begin
      ext_pend_q <= 1'b0;
    end
  end

  a_lsu_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) lsu_gnt_o |-> lsu_req_i)
    else $error("lsu grant without a request");
  a_slv_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) slv_gnt_o |-> slv_req_i)
    else $error("slave grant without a request");
  a_lsu_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_gnt_o && lsu_local) |=> lsu_rvalid_o)
    else $error("lsu bank response not one cycle after its grant");
  a_slv_rvalid: assert property (@(posedge clk) disable iff (!rst_n) slv_gnt_o |=> slv_rvalid_o)
    else $error("slave response not one cycle after its grant");
  a_ext_block: assert property (@(posedge clk) disable iff (!rst_n) ext_pend_q |-> !ext_req_o)
    else $error("ext_req raised while an external response is outstanding");

endmodule

bind mem_region_top mem_region_sva i_sva (.*);

/* dv/mem_region_tb.sv */
// testbench for mem_region_top with random lsu, slave and external traffic
// external bus is a responder with random grant and response delays
// the model memory covers the 4 KiB local space, local addresses alias into it
`timescale 1ns/1ps
`include "mem_region_consts.svh"

module mem_region_tb;

  localparam int N_FILL    = 1024;
  localparam int N_LOCAL   = 48;
  localparam int N_SHARE   = 24;
  localparam int N_ARB     = 32;
  localparam int N_EXT     = 24;
  localparam int N_MIX     = 80;
  localparam int N_TXN     = N_FILL + 2*N_LOCAL + 4*N_SHARE + 2*N_ARB + N_EXT + 2*N_MIX;
  localparam int WD_CYCLES = 20 * N_TXN;

  typedef struct packed {
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } txn_t;

  typedef struct packed {
    logic        rd;
    logic        is_loc;
    logic [31:0] data;
    logic [31:0] due;
  } resp_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        lsu_req_i = 1'b0;
  logic [31:0] lsu_addr_i = '0;
  logic        lsu_we_i = 1'b0;
  logic [3:0]  lsu_be_i = '0;
  logic [31:0] lsu_wdata_i = '0;
  logic        slv_req_i = 1'b0;
  logic [31:0] slv_addr_i = '0;
  logic        slv_we_i = 1'b0;
  logic [3:0]  slv_be_i = '0;
  logic [31:0] slv_wdata_i = '0;
  logic        ext_gnt_i = 1'b0;
  logic        ext_rvalid_i = 1'b0;
  logic [31:0] ext_rdata_i = '0;
  logic        lsu_gnt_o, lsu_rvalid_o, slv_gnt_o, slv_rvalid_o, ext_req_o, ext_we_o;
  logic [31:0] lsu_rdata_o, slv_rdata_o, ext_addr_o, ext_wdata_o;
  logic [3:0]  ext_be_o;

  // model state
  logic [31:0] mem [1024];
  txn_t        lsu_todo[$], slv_todo[$];
  resp_t       lsu_exp[$], slv_exp[$];
  txn_t        lsu_cur = '0;
  txn_t        slv_cur = '0;
  logic        lsu_act = 1'b0;
  logic        slv_act = 1'b0;
  logic        ext_busy = 1'b0;
  int          cyc, errors, checks, tests;

  // external responder state
  logic        rsp_busy = 1'b0;
  int          rsp_cnt, rsp_wait;
  logic [31:0] rsp_addr;

  mem_region_top i_dut (.*);

  always #10 clk = ~clk;

  task automatic check(string what, logic [31:0] got, logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  function automatic txn_t make_txn(logic [31:0] addr, logic we);
    txn_t        t;
    logic [31:0] r;
    r = $urandom;
    t.we = we;
    t.be = r[3:0];
    t.addr = addr;
    t.wdata = $urandom;
    return t;
  endfunction

  function automatic logic [31:0] local_addr();
    logic [31:0] r;
    r = $urandom;
    return {`MR_LOCAL_PREFIX, r[19:2], 2'b00};
  endfunction

  function automatic logic [31:0] ext_addr();
    logic [31:0] r;
    r = $urandom;
    if (r[31:20] == `MR_LOCAL_PREFIX) begin
      r[31] = 1'b1;
    end
    return r;
  endfunction

  task automatic apply_write(txn_t t);
    for (int i = 0; i < 4; i++) begin
      if (t.be[i]) begin
        mem[t.addr[11:2]][8*i +: 8] = t.wdata[8*i +: 8];
      end
    end
  endtask

  // expected grants for this cycle, then log the granted accesses
  task automatic score_grants();
    logic  loc, same, exp_lsu, exp_ext;
    resp_t r;
    loc     = lsu_cur.addr[31:20] == `MR_LOCAL_PREFIX;
    same    = slv_act && slv_cur.addr[3:2] == lsu_cur.addr[3:2];
    exp_ext = lsu_act && !loc && !ext_busy;
    exp_lsu = lsu_act && !ext_busy && (loc ? !same : ext_gnt_i);
    check("slv_gnt_o", 32'(slv_gnt_o), 32'(slv_act));
    check("lsu_gnt_o", 32'(lsu_gnt_o), 32'(exp_lsu));
    check("ext_req_o", 32'(ext_req_o), 32'(exp_ext));
    if (exp_ext) begin
      check("ext_addr_o", ext_addr_o, lsu_cur.addr);
      check("ext_wdata_o", ext_wdata_o, lsu_cur.wdata);
      check("ext_we_o/ext_be_o", {27'd0, ext_we_o, ext_be_o}, {27'd0, lsu_cur.we, lsu_cur.be});
    end
    if (ext_rvalid_i) begin
      ext_busy = 1'b0;
    end
    // reads see the words as they were before this cycle's writes
    if (slv_act) begin
      r = '{rd: !slv_cur.we, is_loc: 1'b1, data: mem[slv_cur.addr[11:2]], due: cyc + 1};
      slv_exp.push_back(r);
    end
    if (exp_lsu) begin
      r = '{rd: !lsu_cur.we, is_loc: loc, data: mem[lsu_cur.addr[11:2]], due: cyc + 1};
      if (!loc) begin
        r.data = lsu_cur.addr ^ 32'hA5A5_5A5A;
        ext_busy = 1'b1;
      end
      lsu_exp.push_back(r);
    end
    if (slv_act) begin
      if (slv_cur.we) begin
        apply_write(slv_cur);
      end
      slv_act = 1'b0;
    end
    if (exp_lsu) begin
      if (lsu_cur.we && loc) begin
        apply_write(lsu_cur);
      end
      lsu_act = 1'b0;
    end
  endtask

  task automatic score_resp(string port, logic valid, logic [31:0] data, ref resp_t q[$]);
    resp_t r;
    if (valid) begin
      if (q.size() == 0) begin
        errors++;
        $display("%s returned a response with no access outstanding at %0d ns", port, $time);
      end else begin
        r = q.pop_front();
        if (r.is_loc) begin
          check({port, " response cycle"}, 32'(cyc), r.due);
        end
        if (r.rd) begin
          check({port, "_rdata_o"}, data, r.data);
        end
      end
    end else if (q.size() > 0 && q[0].is_loc && q[0].due == 32'(cyc)) begin
      errors++;
      $display("%s response missing one cycle after its grant at %0d ns", port, $time);
      void'(q.pop_front());
    end
  endtask

  // request driver for both ports
  always begin
    @(negedge clk);
    if (!lsu_act && lsu_todo.size() > 0) begin
      lsu_cur = lsu_todo.pop_front();
      lsu_act = 1'b1;
    end
    if (!slv_act && slv_todo.size() > 0) begin
      slv_cur = slv_todo.pop_front();
      slv_act = 1'b1;
    end
    lsu_req_i   = lsu_act;
    lsu_addr_i  = lsu_cur.addr;
    lsu_we_i    = lsu_cur.we;
    lsu_be_i    = lsu_cur.be;
    lsu_wdata_i = lsu_cur.wdata;
    slv_req_i   = slv_act;
    slv_addr_i  = slv_cur.addr;
    slv_we_i    = slv_cur.we;
    slv_be_i    = slv_cur.be;
    slv_wdata_i = slv_cur.wdata;
    #5;
    if (rst_n) begin
      score_grants();
    end
  end

  // response monitor
  always begin
    @(negedge clk);
    cyc++;
    #5;
    if (rst_n) begin
      score_resp("lsu", lsu_rvalid_o, lsu_rdata_o, lsu_exp);
      score_resp("slv", slv_rvalid_o, slv_rdata_o, slv_exp);
    end
  end

  // external bus: grant after 0 to 2 cycles, respond 1 to 4 cycles later
  always begin
    @(negedge clk);
    ext_rvalid_i = 1'b0;
    if (rsp_busy) begin
      rsp_cnt--;
      if (rsp_cnt == 0) begin
        ext_rvalid_i = 1'b1;
        ext_rdata_i  = rsp_addr ^ 32'hA5A5_5A5A;
        rsp_busy     = 1'b0;
      end
    end
    ext_gnt_i = !rsp_busy && rsp_wait == 0;
    #5;
    if (rst_n && ext_req_o) begin
      if (ext_gnt_i) begin
        rsp_busy = 1'b1;
        rsp_cnt  = 1 + int'($urandom % 4);
        rsp_addr = ext_addr_o;
        rsp_wait = int'($urandom % 3);
      end else if (rsp_wait > 0) begin
        rsp_wait--;
      end
    end
  end

  task automatic drain();
    do begin
      @(negedge clk);
      #6;
    end while (lsu_todo.size() > 0 || slv_todo.size() > 0 || lsu_act || slv_act ||
               lsu_exp.size() > 0 || slv_exp.size() > 0 || ext_busy);
  endtask

  task automatic check_idle();
    check("grants, rvalids and ext_req", {27'd0, lsu_gnt_o, lsu_rvalid_o, slv_gnt_o,
          slv_rvalid_o, ext_req_o}, 32'd0);
  endtask

  task automatic end_test(string name, int e0);
    tests++;
    $display("test %s finished with %0d errors", name, errors - e0);
  endtask

  initial begin
    logic [31:0] addrs [64];
    logic [31:0] a, b, r;
    txn_t        t;
    int          e0;
    void'($urandom(32'he88b));
    rsp_wait = int'($urandom % 3);
    e0 = errors;
    @(negedge clk);
    #5;
    check_idle();
    @(negedge clk);
    rst_n = 1'b1;
    repeat (3) begin
      @(negedge clk);
      #5;
      check_idle();
    end
    end_test("reset", e0);

    // every word gets a known value first
    e0 = errors;
    for (int i = 0; i < N_FILL; i++) begin
      t = make_txn(32'(i) << 2, 1'b1);
      t.be = 4'hF;
      t.wdata = 32'h5EED_0000 ^ (32'(i) * 32'h0001_0193) ^ (32'(i) << 22);
      slv_todo.push_back(t);
    end
    drain();
    end_test("preload", e0);

    e0 = errors;
    for (int i = 0; i < N_LOCAL; i++) begin
      addrs[i] = local_addr();
      lsu_todo.push_back(make_txn(addrs[i], 1'b1));
    end
    drain();
    for (int i = 0; i < N_LOCAL; i++) begin
      r = $urandom;
      lsu_todo.push_back(make_txn({addrs[i][31:20], r[19:12], addrs[i][11:0]}, 1'b0));
    end
    drain();
    end_test("local", e0);

    e0 = errors;
    for (int i = 0; i < N_SHARE; i++) begin
      addrs[i] = $urandom;
      slv_todo.push_back(make_txn(addrs[i], 1'b1));
    end
    drain();
    for (int i = 0; i < N_SHARE; i++) begin
      lsu_todo.push_back(make_txn({`MR_LOCAL_PREFIX, addrs[i][19:0]}, 1'b0));
    end
    drain();
    for (int i = 0; i < N_SHARE; i++) begin
      addrs[i] = local_addr();
      lsu_todo.push_back(make_txn(addrs[i], 1'b1));
    end
    drain();
    for (int i = 0; i < N_SHARE; i++) begin
      r = $urandom;
      slv_todo.push_back(make_txn(addrs[i] ^ (r & 32'hFFFF_F000), 1'b0));
    end
    drain();
    end_test("sharing", e0);

    // even pairs collide on one bank
    e0 = errors;
    for (int i = 0; i < N_ARB; i++) begin
      a = $urandom;
      b = local_addr();
      r = $urandom;
      if (i % 2 == 0) begin
        b[3:2] = a[3:2];
      end
      slv_todo.push_back(make_txn(a, r[0]));
      lsu_todo.push_back(make_txn(b, r[1]));
      drain();
    end
    end_test("arbitration", e0);

    e0 = errors;
    for (int i = 0; i < N_EXT; i++) begin
      r = $urandom;
      lsu_todo.push_back(make_txn(ext_addr(), r[0]));
    end
    drain();
    end_test("external", e0);

    e0 = errors;
    for (int i = 0; i < N_MIX; i++) begin
      r = $urandom;
      lsu_todo.push_back(make_txn(r[1] ? ext_addr() : local_addr(), r[0]));
      if (r[2] && r[3]) begin
        slv_todo.push_back(make_txn($urandom, r[4]));
      end
    end
    drain();
    end_test("ordering", e0);

    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog sized from the transaction count
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* files.f */
+incdir+rtl
rtl/mem_region_pkg.sv
rtl/mem_port_if.sv
rtl/lsu_addr_router.sv
rtl/mem_bank.sv
rtl/resp_merge.sv
rtl/mem_region_top.sv
dv/mem_region_sva.sv
dv/mem_region_tb.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module mem_region_tb \
  --Mdir obj_dir -o mem_region_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/mem_region_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
